// ==== hw/chimera_pkg.sv ====
// Shared widths and address map of the control island
// Register offsets and the boot ROM image
// Bus address word with register and ROM views
// Bus FSM state type

package chimera_pkg;

   localparam int unsigned AddrWidth   = 32;
   localparam int unsigned DataWidth   = 32;
   localparam int unsigned NumClusters = 5;

   // Region field, address bits 13:12
   localparam logic [1:0] RegionRegs    = 2'd0;
   localparam logic [1:0] RegionBootRom = 2'd1;

   // Word offsets inside the register region
   localparam logic [3:0] RegClkGateEn  = 4'd0;
   localparam logic [3:0] RegWideBypass = 4'd1;

   localparam int unsigned BootRomDepth = 16;

   // Park the hart until the host releases it
   localparam logic [DataWidth-1:0] BootRomImage [BootRomDepth] = '{
      32'hf1402573, 32'h00000597, 32'h03c58593, 32'h30405073,
      32'h10500073, 32'hffdff06f, 32'h00000013, 32'h00000013,
      32'h10000000, 32'h20000000, 32'h30000000, 32'h40000000,
      32'h0000c0de, 32'h0badf00d, 32'hdeadbeef, 32'h5a5aa5a5
   };

   typedef union packed {
      struct packed {
         logic [17:0] unused_hi;
         logic [1:0]  region;
         logic [5:0]  unused_mid;
         logic [3:0]  reg_idx;
         logic [1:0]  unused_lo;
      } reg_view;
      struct packed {
         logic [17:0] unused_hi;
         logic [1:0]  region;
         logic [5:0]  unused_mid;
         logic [3:0]  rom_idx;
         logic [1:0]  unused_lo;
      } rom_view;
   } wb_addr_u;

   typedef enum logic [1:0] {
      IDLE,
      ROM_WAIT,
      RESP
   } fsm_state_e;

endpackage

// ==== hw/wb_slave_fsm.sv ====
// Wishbone classic slave FSM
// Region decode, register strobes, ROM request and ack/err sequencing

`timescale 1ns/10ps

module wb_slave_fsm (
   input  logic                              soc_clk_i,
   input  logic                              rst_i,
   input  logic                              wb_cyc_i,
   input  logic                              wb_stb_i,
   input  logic                              wb_we_i,
   input  logic [chimera_pkg::AddrWidth-1:0] wb_adr_i,
   input  logic [chimera_pkg::DataWidth-1:0] wb_dat_i,
   output logic [chimera_pkg::DataWidth-1:0] wb_dat_o,
   output logic                              wb_ack_o,
   output logic                              wb_err_o,
   output logic                              reg_we_o,
   output logic [3:0]                        reg_idx_o,
   output logic [chimera_pkg::DataWidth-1:0] reg_wdata_o,
   input  logic [chimera_pkg::DataWidth-1:0] reg_rdata_i,
   input  logic                              reg_hit_i,
   output logic                              rom_req_o,
   output logic [3:0]                        rom_idx_o,
   input  logic [chimera_pkg::DataWidth-1:0] rom_rdata_i
);

   chimera_pkg::wb_addr_u   adr;
   chimera_pkg::fsm_state_e state_q, state_d;
   logic                    err_q, err_d;
   logic                    rom_q, rom_d;

   assign adr = wb_adr_i;

   always_comb begin
      state_d   = state_q;
      err_d     = err_q;
      rom_d     = rom_q;
      rom_req_o = 1'b0;
      case (state_q)
         chimera_pkg::IDLE: begin
            if (wb_cyc_i && wb_stb_i) begin
               err_d = 1'b0;
               rom_d = 1'b0;
               case (adr.reg_view.region)
                  chimera_pkg::RegionRegs: begin
                     err_d   = ~reg_hit_i;
                     state_d = chimera_pkg::RESP;
                  end
                  chimera_pkg::RegionBootRom: begin
                     // ROM is read only
                     if (wb_we_i) begin
                        err_d   = 1'b1;
                        state_d = chimera_pkg::RESP;
                     end else begin
                        rom_req_o = 1'b1;
                        rom_d     = 1'b1;
                        state_d   = chimera_pkg::ROM_WAIT;
                     end
                  end
                  default: begin
                     err_d   = 1'b1;
                     state_d = chimera_pkg::RESP;
                  end
               endcase
            end
         end
         chimera_pkg::ROM_WAIT: state_d = chimera_pkg::RESP;
         chimera_pkg::RESP:     state_d = chimera_pkg::IDLE;
         default:               state_d = chimera_pkg::IDLE;
      endcase
   end

   always_ff @(posedge soc_clk_i) begin
      if (rst_i) begin
         state_q <= chimera_pkg::IDLE;
         err_q   <= 1'b0;
         rom_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         err_q   <= err_d;
         rom_q   <= rom_d;
      end
   end

   assign wb_ack_o = (state_q == chimera_pkg::RESP) && !err_q;
   assign wb_err_o = (state_q == chimera_pkg::RESP) && err_q;

   // Write lands at the edge closing the ack cycle
   assign reg_we_o    = wb_ack_o && !rom_q && wb_we_i;
   assign reg_idx_o   = adr.reg_view.reg_idx;
   assign reg_wdata_o = wb_dat_i;
   assign rom_idx_o   = adr.rom_view.rom_idx;

   assign wb_dat_o = (wb_ack_o && !wb_we_i) ? (rom_q ? rom_rdata_i : reg_rdata_i) : '0;

endmodule

// ==== hw/chimera_regs.sv ====
// Control registers of the island
// Cluster clock-gate enables and wide memory bypass, with read-back

`timescale 1ns/10ps

module chimera_regs #(
   parameter int unsigned NumClusters = 5
) (
   input  logic                              soc_clk_i,
   input  logic                              rst_i,
   input  logic                              reg_we_i,
   input  logic [3:0]                        reg_idx_i,
   input  logic [chimera_pkg::DataWidth-1:0] reg_wdata_i,
   output logic [chimera_pkg::DataWidth-1:0] reg_rdata_o,
   output logic                              reg_hit_o,
   output logic [NumClusters-1:0]            gate_en_o,
   output logic                              wide_mem_bypass_o
);

   logic [NumClusters-1:0] gate_en_q;
   logic                   bypass_q;

   always_ff @(posedge soc_clk_i) begin
      if (rst_i) begin
         gate_en_q <= '0;
         bypass_q  <= 1'b0;
      end else if (reg_we_i) begin
         // Only the defined field bits are kept
         if (reg_idx_i == chimera_pkg::RegClkGateEn) begin
            gate_en_q <= reg_wdata_i[NumClusters-1:0];
         end
         if (reg_idx_i == chimera_pkg::RegWideBypass) begin
            bypass_q <= reg_wdata_i[0];
         end
      end
   end

   always_comb begin
      reg_rdata_o = '0;
      reg_hit_o   = 1'b0;
      case (reg_idx_i)
         chimera_pkg::RegClkGateEn: begin
            reg_rdata_o[NumClusters-1:0] = gate_en_q;
            reg_hit_o                    = 1'b1;
         end
         chimera_pkg::RegWideBypass: begin
            reg_rdata_o[0] = bypass_q;
            reg_hit_o      = 1'b1;
         end
         default: ;
      endcase
   end

   assign gate_en_o         = gate_en_q;
   assign wide_mem_bypass_o = bypass_q;

endmodule

// ==== hw/snitch_bootrom.sv ====
// Cluster boot ROM
// Word lookup in the boot image with a registered read port

`timescale 1ns/10ps

module snitch_bootrom (
   input  logic                              soc_clk_i,
   input  logic                              rst_i,
   input  logic                              req_i,
   input  logic [3:0]                        idx_i,
   output logic [chimera_pkg::DataWidth-1:0] data_o
);

   logic [chimera_pkg::DataWidth-1:0] rom_word;
   logic [chimera_pkg::DataWidth-1:0] data_q;

   assign rom_word = chimera_pkg::BootRomImage[idx_i];

   // Word is held until the next request
   always_ff @(posedge soc_clk_i) begin
      if (rst_i) begin
         data_q <= '0;
      end else if (req_i) begin
         data_q <= rom_word;
      end
   end

   assign data_o = data_q;

endmodule

// ==== hw/cluster_clk_gates.sv ====
// Per-cluster clock gates
// Low-transparent enable latch and AND gate on the cluster clock

`timescale 1ns/10ps

module cluster_clk_gates #(
   parameter int unsigned NumClusters = 5
) (
   input  logic                   clu_clk_i,
   input  logic [NumClusters-1:0] gate_en_i,
   output logic [NumClusters-1:0] clu_clk_o
);

   logic [NumClusters-1:0] clk_en_q;

   // Enable only changes while the clock is low, so no glitches
   always_latch begin
      if (!clu_clk_i) begin
         clk_en_q <= ~gate_en_i;
      end
   end

   assign clu_clk_o = clk_en_q & {NumClusters{clu_clk_i}};

endmodule

// ==== hw/chimera_ctrl_top.sv ====
// Control island top level
// Wishbone slave FSM, control registers, boot ROM and cluster clock gates

`timescale 1ns/10ps

module chimera_ctrl_top #(
   parameter int unsigned NumClusters = chimera_pkg::NumClusters
) (
   input  logic                              soc_clk_i,
   input  logic                              clu_clk_i,
   input  logic                              rst_i,
   input  logic                              wb_cyc_i,
   input  logic                              wb_stb_i,
   input  logic                              wb_we_i,
   input  logic [chimera_pkg::AddrWidth-1:0] wb_adr_i,
   input  logic [chimera_pkg::DataWidth-1:0] wb_dat_i,
   output logic [chimera_pkg::DataWidth-1:0] wb_dat_o,
   output logic                              wb_ack_o,
   output logic                              wb_err_o,
   output logic [NumClusters-1:0]            clu_clk_o,
   output logic                              wide_mem_bypass_o
);

   logic                              reg_we;
   logic [3:0]                        reg_idx;
   logic [chimera_pkg::DataWidth-1:0] reg_wdata;
   logic [chimera_pkg::DataWidth-1:0] reg_rdata;
   logic                              reg_hit;
   logic                              rom_req;
   logic [3:0]                        rom_idx;
   logic [chimera_pkg::DataWidth-1:0] rom_rdata;
   logic [NumClusters-1:0]            gate_en;

   wb_slave_fsm i_wb_slave (
      .soc_clk_i   (soc_clk_i),
      .rst_i       (rst_i),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .wb_we_i     (wb_we_i),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_o    (wb_ack_o),
      .wb_err_o    (wb_err_o),
      .reg_we_o    (reg_we),
      .reg_idx_o   (reg_idx),
      .reg_wdata_o (reg_wdata),
      .reg_rdata_i (reg_rdata),
      .reg_hit_i   (reg_hit),
      .rom_req_o   (rom_req),
      .rom_idx_o   (rom_idx),
      .rom_rdata_i (rom_rdata)
   );

   chimera_regs #(
      .NumClusters (NumClusters)
   ) i_regs (
      .soc_clk_i         (soc_clk_i),
      .rst_i             (rst_i),
      .reg_we_i          (reg_we),
      .reg_idx_i         (reg_idx),
      .reg_wdata_i       (reg_wdata),
      .reg_rdata_o       (reg_rdata),
      .reg_hit_o         (reg_hit),
      .gate_en_o         (gate_en),
      .wide_mem_bypass_o (wide_mem_bypass_o)
   );

   snitch_bootrom i_bootrom (
      .soc_clk_i (soc_clk_i),
      .rst_i     (rst_i),
      .req_i     (rom_req),
      .idx_i     (rom_idx),
      .data_o    (rom_rdata)
   );

   cluster_clk_gates #(
      .NumClusters (NumClusters)
   ) i_clk_gates (
      .clu_clk_i (clu_clk_i),
      .gate_en_i (gate_en),
      .clu_clk_o (clu_clk_o)
   );

endmodule

// ==== tb/tb_chimera_ctrl.sv ====
// Testbench for the control island top level
// Replays the bus operations and clock checks of the stimulus file

`timescale 1ns/10ps

module tb_chimera_ctrl;

   localparam int unsigned NumClusters = chimera_pkg::NumClusters;
   localparam int unsigned MaxOps      = 64;
   localparam int unsigned Fields      = 5;
   localparam int          Timeout     = 10;

   logic                   clk;
   logic                   rst_i;
   logic                   wb_cyc_i;
   logic                   wb_stb_i;
   logic                   wb_we_i;
   logic [31:0]            wb_adr_i;
   logic [31:0]            wb_dat_i;
   logic [31:0]            wb_dat_o;
   logic                   wb_ack_o;
   logic                   wb_err_o;
   logic [NumClusters-1:0] clu_clk_o;
   logic                   wide_mem_bypass_o;

   logic [31:0] stim [MaxOps*Fields];
   logic        exp_bypass;

   chimera_ctrl_top #(
      .NumClusters (NumClusters)
   ) uut (
      .soc_clk_i         (clk),
      .clu_clk_i         (clk),
      .rst_i             (rst_i),
      .wb_cyc_i          (wb_cyc_i),
      .wb_stb_i          (wb_stb_i),
      .wb_we_i           (wb_we_i),
      .wb_adr_i          (wb_adr_i),
      .wb_dat_i          (wb_dat_i),
      .wb_dat_o          (wb_dat_o),
      .wb_ack_o          (wb_ack_o),
      .wb_err_o          (wb_err_o),
      .clu_clk_o         (clu_clk_o),
      .wide_mem_bypass_o (wide_mem_bypass_o)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_fail(input string reason);
      $display("%s", reason);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
      report_fail($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, expected));
   endtask

   task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [31:0] exp_data, input logic exp_err);
      int cycles;
      int exp_lat;
      cycles = 0;
      // ROM reads wait one extra cycle for the registered word
      exp_lat = (addr[13:12] == chimera_pkg::RegionBootRom && !we) ? 2 : 1;
      @(posedge clk);
      #1;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = addr;
      wb_dat_i = wdata;
      do begin
         @(negedge clk);
         cycles++;
         assert (cycles <= Timeout) else
            report_fail("wait for ack or err timed out after 10 cycles");
      end while (!wb_ack_o && !wb_err_o);
      assert (wb_err_o == exp_err) else report_value("wb_err_o", 32'(wb_err_o), 32'(exp_err));
      assert (wb_ack_o == !exp_err) else report_value("wb_ack_o", 32'(wb_ack_o), 32'(!exp_err));
      assert (cycles - 1 == exp_lat) else
         report_value("response latency", 32'(cycles - 1), 32'(exp_lat));
      if (!we) begin
         assert (wb_dat_o == exp_data) else report_value("wb_dat_o", wb_dat_o, exp_data);
      end
      @(posedge clk);
      #1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      wb_adr_i = '0;
      wb_dat_i = '0;
      assert (!wb_ack_o && !wb_err_o) else report_fail("response lasted more than one cycle");
      if (we && !exp_err && addr[13:12] == 2'd0 && addr[5:2] == 4'd1) begin
         exp_bypass = wdata[0];
      end
      assert (wide_mem_bypass_o == exp_bypass) else
         report_value("wide_mem_bypass_o", 32'(wide_mem_bypass_o), 32'(exp_bypass));
   endtask

   // Gated clusters stay low, the others follow the clock
   task automatic check_clocks(input logic [31:0] pattern);
      logic [NumClusters-1:0] exp_high;
      exp_high = ~pattern[NumClusters-1:0];
      repeat (4) begin
         @(posedge clk);
         #25;
         assert (clu_clk_o == exp_high) else
            report_value("clu_clk_o", 32'(clu_clk_o), 32'(exp_high));
         @(negedge clk);
         #25;
         assert (clu_clk_o == '0) else report_value("clu_clk_o", 32'(clu_clk_o), 32'h0);
      end
   endtask

   initial begin
      logic [8:0] base;
      int         n_ops;
      rst_i      = 1'b1;
      wb_cyc_i   = 1'b0;
      wb_stb_i   = 1'b0;
      wb_we_i    = 1'b0;
      wb_adr_i   = '0;
      wb_dat_i   = '0;
      exp_bypass = 1'b0;
      base       = '0;
      n_ops      = 0;
      $readmemh("tb/chimera_stimulus.txt", stim);
      repeat (5) @(posedge clk);
      #1;
      rst_i = 1'b0;
      assert (!wb_ack_o && !wb_err_o) else report_fail("ack or err is high after reset");
      assert (wide_mem_bypass_o == 1'b0) else
         report_value("wide_mem_bypass_o", 32'(wide_mem_bypass_o), 32'h0);
      while (stim[base] !== 32'hff) begin
         case (stim[base])
            32'd0: bus_access(1'b0, stim[base+9'd1], stim[base+9'd2], stim[base+9'd3],
                              stim[base+9'd4][0]);
            32'd1: bus_access(1'b1, stim[base+9'd1], stim[base+9'd2], stim[base+9'd3],
                              stim[base+9'd4][0]);
            32'd2: check_clocks(stim[base+9'd2]);
            default: report_fail("unknown operation in the stimulus file");
         endcase
         base = base + 9'd5;
         n_ops++;
         assert (n_ops < MaxOps) else report_fail("stimulus file has no end record");
      end
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// ==== tb/chimera_stimulus.txt ====
// op (0 read, 1 write, 2 clock check), address, write data or gate pattern,
// expected read data, response (0 ack, 1 err); op ff ends the list
0 00000000 00000000 00000000 0
0 00000004 00000000 00000000 0
2 00000000 00000000 00000000 0
1 00000000 ffffffff 00000000 0
0 00000000 00000000 0000001f 0
1 00000004 ffffffff 00000000 0
0 00000004 00000000 00000001 0
2 00000000 0000001f 00000000 0
1 00000000 00000015 00000000 0
2 00000000 00000015 00000000 0
1 00000004 00000000 00000000 0
0 00001000 00000000 f1402573 0
0 00001004 00000000 00000597 0
0 00001008 00000000 03c58593 0
0 0000100c 00000000 30405073 0
0 00001010 00000000 10500073 0
0 00001014 00000000 ffdff06f 0
0 00001018 00000000 00000013 0
0 0000101c 00000000 00000013 0
0 00001020 00000000 10000000 0
0 00001024 00000000 20000000 0
0 00001028 00000000 30000000 0
0 0000102c 00000000 40000000 0
0 00001030 00000000 0000c0de 0
0 00001034 00000000 0badf00d 0
0 00001038 00000000 deadbeef 0
0 0000103c 00000000 5a5aa5a5 0
1 00001000 12345678 00000000 1
0 00002000 00000000 00000000 1
1 00003000 ffffffff 00000000 1
0 00000008 00000000 00000000 1
1 00000008 ffffffff 00000000 1
0 00000000 00000000 00000015 0
0 00000004 00000000 00000000 0
ff 00000000 00000000 00000000 0

// ==== chimera_ctrl_top.f ====
hw/chimera_pkg.sv
hw/wb_slave_fsm.sv
hw/chimera_regs.sv
hw/snitch_bootrom.sv
hw/cluster_clk_gates.sv
hw/chimera_ctrl_top.sv
tb/tb_chimera_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -f chimera_ctrl_top.f --top-module tb_chimera_ctrl -o tb_sim &&
./obj_dir/tb_sim || exit 1
